//--- stack_decoder.f
+incdir+common
common/decoder_pkg.sv
common/decoder_if.sv
decode/exec_decoder.sv
decode/mem_decoder.sv
src/operand_router.sv
src/stack_decoder.sv
tests/stack_decoder_properties.sv
tests/stack_decoder_tb.sv

//--- Bender.yml
package:
  name: stack_decoder

sources:
  - include_dirs:
      - common
    files:
      - common/decoder_pkg.sv
      - common/decoder_if.sv
      - decode/exec_decoder.sv
      - decode/mem_decoder.sv
      - src/operand_router.sv
      - src/stack_decoder.sv

  - target: test
    include_dirs:
      - common
    files:
      - tests/stack_decoder_properties.sv
      - tests/stack_decoder_tb.sv

//--- tests/stack_decoder_tb.sv
`timescale 1ns/1ns
`default_nettype none

module stack_decoder_tb;
	import decoder_pkg::*;

	localparam int clk_period = 40;
	localparam int total_cycles = 16 + 1 + 128 + 129 + 8 + 24;     // Reset, sweeps, inversion, routing
	localparam int timeout_margin = 2000;

	logic       clk;
	logic       rst;
	opcode_t    opcode;
	operand_t   operand;
	data_t      mem_data_in;
	data_t      io_in;
	logic       dsp_push;
	logic       dsp_pop;
	alu_op_e    ula_op;
	data_t      ula_data;
	logic       mem_wr;
	dmem_addr_t mem_addr;
	logic       req_in;
	logic       out_en;
	logic       srf;
	logic       ldi;
	logic       inv;

	opcode_t     prev_op;                 // Opcode captured at the last rising edge
	logic [31:0] lcg_state = 32'd6232;
	int          errors = 0;
	int          tests_run = 0;

	stack_decoder dut0 (
		.clk         (clk),
		.rst         (rst),
		.opcode      (opcode),
		.operand     (operand),
		.dsp_push    (dsp_push),
		.dsp_pop     (dsp_pop),
		.ula_op      (ula_op),
		.ula_data    (ula_data),
		.mem_wr      (mem_wr),
		.mem_addr    (mem_addr),
		.mem_data_in (mem_data_in),
		.io_in       (io_in),
		.req_in      (req_in),
		.out_en      (out_en),
		.srf         (srf),
		.ldi         (ldi),
		.inv         (inv)
	);

	always #(clk_period / 2) clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Reference decode, registered path
	function automatic alu_op_e ref_alu(input int op);
		case (op)
			0, 1, 3, 10, 50, 52, 64: return alu_load;
			12:     return alu_neg;
			13, 14: return alu_add;
			15, 16: return alu_mul;
			17, 18: return alu_div;
			19, 20: return alu_mod;
			21, 22: return alu_and;
			23, 24: return alu_land;
			25, 26: return alu_or;
			27, 28: return alu_lor;
			29, 30: return alu_xor;
			31:     return alu_inv;
			32:     return alu_linv;
			33, 34: return alu_equ;
			35, 36: return alu_gre;
			37, 38: return alu_les;
			39, 40: return alu_shr;
			41, 42: return alu_shl;
			43, 44: return alu_srs;
			45:     return alu_pst;
			46, 51: return alu_sign;
			47:     return alu_norm;
			49:     return alu_abs;
			default: return alu_nop;
		endcase
	endfunction

	// Reference decode, combinational path
	function automatic logic ref_pop(input int op);
		if (op inside {3, 9, 11, 46, 53, 64})
			return 1'b1;
		return (op >= 14) && (op <= 44) && (op % 2 == 0) && (op != 32);     // Stack forms
	endfunction

	task automatic check_alu_op(input string name, input alu_op_e act, input alu_op_e exp);
		if (act !== exp) begin
			$display("** Error: %s = 0x%0h, expected 0x%0h (opcode 0x%0h)", name, act, exp, opcode);
			errors++;
		end
	endtask

	task automatic check_data(input string name, input data_t act, input data_t exp);
		if (act !== exp) begin
			$display("** Error: %s = 0x%0h, expected 0x%0h", name, act, exp);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input dmem_addr_t act, input dmem_addr_t exp);
		if (act !== exp) begin
			$display("** Error: %s = 0x%0h, expected 0x%0h", name, act, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic act, input logic exp);
		if (act !== exp) begin
			$display("** Error: %s = 0x%0h, expected 0x%0h (opcode 0x%0h)", name, act, exp, opcode);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int start);
		tests_run++;
		$display("%s: %s, %0d errors", name, (errors == start) ? "ok" : "failed", errors - start);
	endtask

	task automatic drive(input opcode_t op, input operand_t opnd, input data_t md, input data_t io);
		@(posedge clk);
		#5;
		prev_op     = opcode;
		opcode      = op;
		operand     = opnd;
		mem_data_in = md;
		io_in       = io;
	endtask

	task automatic check_reset_state();
		check_alu_op("ula_op", ula_op, alu_nop);
		check_bit("srf", srf, 1'b0);
		check_bit("req_in", req_in, 1'b0);
		check_bit("out_en", out_en, 1'b0);
	endtask

	task automatic test_reset();
		int start;
		start = errors;
		for (int i = 0; i < 16; i++) begin
			@(posedge clk);
			#5;
			if (i == 15) begin
				rst    = 1'b0;
				opcode = 7'h7f;     // Unused code, registers nothing
			end
			@(negedge clk);
			check_reset_state();
		end
		drive(7'h7f, '0, '0, '0);
		@(negedge clk);
		check_reset_state();
		report_test("reset", start);
	endtask

	task automatic test_comb_sweep();
		int          start;
		logic [31:0] rnd;
		start = errors;
		for (int i = 0; i < 128; i++) begin
			rnd = lcg_next();
			drive(opcode_t'(i), rnd[8:0], lcg_next(), lcg_next());
			@(negedge clk);
			check_bit("mem_wr", mem_wr, i inside {1, 2, 3, 4});
			check_bit("dsp_push", dsp_push, i inside {1, 4});
			check_bit("dsp_pop", dsp_pop, ref_pop(i));
			check_bit("ldi", ldi, i inside {50, 52});
		end
		report_test("combinational sweep", start);
	endtask

	task automatic test_reg_sweep();
		int start;
		start = errors;
		for (int i = 0; i <= 128; i++) begin
			drive((i == 128) ? 7'h7f : opcode_t'(i), '0, '0, '0);
			@(negedge clk);
			check_alu_op("ula_op", ula_op, ref_alu(int'(prev_op)));
			check_bit("srf", srf, int'(prev_op) inside {9, 53});
			check_bit("out_en", out_en, prev_op == 7'd11);
			check_bit("req_in", req_in, prev_op == 7'd10);
			check_bit("inv", inv, (opcode == 7'd50) || (prev_op == 7'd53));
		end
		report_test("registered sweep", start);
	endtask

	task automatic test_inversion();
		int start;
		int seq [8];
		start = errors;
		seq = '{50, 53, 0, 52, 9, 52, 9, 127};     // ILDI, ISRF then plain LDI and SRF
		for (int i = 0; i < 8; i++) begin
			drive(opcode_t'(seq[i]), '0, '0, '0);
			@(negedge clk);
			check_bit("inv", inv, (opcode == 7'd50) || (prev_op == 7'd53));
		end
		report_test("inversion", start);
	endtask

	task automatic test_routing();
		int          start;
		logic [31:0] rnd;
		operand_t    opnd;
		data_t       md;
		data_t       io;
		start = errors;
		for (int i = 0; i < 24; i++) begin
			rnd  = lcg_next();
			opnd = rnd[8:0];
			md   = lcg_next();
			io   = lcg_next();
			drive((i % 3 == 0) ? 7'd10 : 7'd13, opnd, md, io);
			@(negedge clk);
			check_addr("mem_addr", mem_addr, opnd[7:0]);
			check_bit("req_in", req_in, prev_op == 7'd10);
			check_data("ula_data", ula_data, (prev_op == 7'd10) ? io : md);
		end
		report_test("routing", start);
	endtask

	initial begin
		clk         = 1'b0;
		rst         = 1'b1;
		opcode      = 7'd53;     // ISRF held in reset must not reach the registers
		operand     = '0;
		mem_data_in = '0;
		io_in       = '0;
		prev_op     = 7'h7f;
		test_reset();
		test_comb_sweep();
		test_reg_sweep();
		test_inversion();
		test_routing();
		errors += dut0.props0.assert_errors;
		$display("Tests run: %0d, errors: %0d, assertion failures: %0d",
			tests_run, errors, dut0.props0.assert_errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#(clk_period * total_cycles + timeout_margin);
		$display("Watchdog expired before all tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/stack_decoder_properties.sv
`timescale 1ns/1ns
`default_nettype none

module stack_decoder_properties (
	input logic                 clk,
	input logic                 rst,
	input decoder_pkg::opcode_t opcode,
	input decoder_pkg::alu_op_e ula_op,
	input logic                 dsp_push,
	input logic                 dsp_pop,
	input logic                 mem_wr,
	input logic                 ldi,
	input logic                 inv,
	input logic                 srf,
	input logic                 req_in,
	input logic                 out_en
);
	import decoder_pkg::*;

	int assert_errors = 0;     // Failure count, read by the testbench

	push_pop_excl: assert property (@(posedge clk) disable iff (rst) !(dsp_push && dsp_pop))
		else begin
			$error("dsp_push and dsp_pop high together");
			assert_errors++;
		end

	ldi_no_write: assert property (@(posedge clk) disable iff (rst) ldi |-> !mem_wr)
		else begin
			$error("mem_wr high during an indirect load");
			assert_errors++;
		end

	ildi_inv: assert property (@(posedge clk) disable iff (rst) (opcode == op_ildi) |-> inv)
		else begin
			$error("inv low in an ILDI cycle");
			assert_errors++;
		end

	// ISRF sets inv in the following cycle
	isrf_inv: assert property (@(posedge clk) disable iff (rst)
		($past(opcode == op_isrf) && !$past(rst)) |-> inv)
		else begin
			$error("inv low after an ISRF cycle");
			assert_errors++;
		end

	reset_clean: assert property (@(posedge clk)
		$fell(rst) |-> (ula_op == alu_nop) && !srf && !req_in && !out_en)
		else begin
			$error("registered outputs not cleared by reset");
			assert_errors++;
		end

endmodule

bind stack_decoder stack_decoder_properties props0 (
	.clk      (clk),
	.rst      (rst),
	.opcode   (opcode),
	.ula_op   (ula_op),
	.dsp_push (dsp_push),
	.dsp_pop  (dsp_pop),
	.mem_wr   (mem_wr),
	.ldi      (ldi),
	.inv      (inv),
	.srf      (srf),
	.req_in   (req_in),
	.out_en   (out_en)
);

`default_nettype wire

//--- src/stack_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module stack_decoder (
	input  logic                    clk,
	input  logic                    rst,
	input  decoder_pkg::opcode_t    opcode,
	input  decoder_pkg::operand_t   operand,
	output logic                    dsp_push,
	output logic                    dsp_pop,
	output decoder_pkg::alu_op_e    ula_op,
	output decoder_pkg::data_t      ula_data,
	output logic                    mem_wr,
	output decoder_pkg::dmem_addr_t mem_addr,
	input  decoder_pkg::data_t      mem_data_in,
	input  decoder_pkg::data_t      io_in,
	output logic                    req_in,
	output logic                    out_en,
	output logic                    srf,
	output logic                    ldi,
	output logic                    inv
);

	exec_ctrl_if exec_ctrl ();
	mem_ctrl_if  mem_ctrl ();

	exec_decoder exec_dec0 (
		.clk    (clk),
		.rst    (rst),
		.opcode (opcode),
		.ctrl   (exec_ctrl)
	);

	mem_decoder mem_dec0 (
		.opcode (opcode),
		.ctrl   (mem_ctrl)
	);

	operand_router router0 (
		.exec        (exec_ctrl),
		.mem         (mem_ctrl),
		.operand     (operand),
		.mem_data_in (mem_data_in),
		.io_in       (io_in),
		.ula_data    (ula_data),
		.mem_addr    (mem_addr),
		.inv         (inv)
	);

	// Registered controls
	assign ula_op = exec_ctrl.alu_op;
	assign srf    = exec_ctrl.srf;
	assign req_in = exec_ctrl.req_in;
	assign out_en = exec_ctrl.out_en;

	// Same-cycle controls
	assign mem_wr   = mem_ctrl.mem_wr;
	assign dsp_push = mem_ctrl.push;
	assign dsp_pop  = mem_ctrl.pop;
	assign ldi      = mem_ctrl.ldi;

endmodule

`default_nettype wire

//--- src/operand_router.sv
`include "decoder_settings.svh"
`timescale 1ns/1ns
`default_nettype none

module operand_router (
	exec_ctrl_if.dst               exec,
	mem_ctrl_if.dst                mem,
	input  decoder_pkg::operand_t  operand,
	input  decoder_pkg::data_t     mem_data_in,
	input  decoder_pkg::data_t     io_in,
	output decoder_pkg::data_t     ula_data,
	output decoder_pkg::dmem_addr_t mem_addr,
	output logic                   inv
);

	// ILDI flags this cycle, ISRF flags the cycle after
	assign inv = mem.invl | exec.invr;

	// IN result reaches the ALU one cycle after the opcode
	assign ula_data = exec.req_in ? io_in : mem_data_in;

	assign mem_addr = operand[`DEC_DMEM_ADDR_W-1:0];     // Upper operand bits unused here

endmodule

`default_nettype wire

//--- decode/mem_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module mem_decoder (
	input  decoder_pkg::opcode_t opcode,
	mem_ctrl_if.src              ctrl
);
	import decoder_pkg::*;

	// Same-cycle decode so memory and stack act with the opcode
	always_comb begin
		ctrl.mem_wr = 1'b0;
		ctrl.push   = 1'b0;
		ctrl.pop    = 1'b0;
		ctrl.ldi    = 1'b0;
		ctrl.invl   = 1'b0;
		case (opcode)
			op_pld, op_push: begin
				ctrl.mem_wr = 1'b1;
				ctrl.push   = 1'b1;     // Accumulator goes onto the stack
			end
			op_set: begin
				ctrl.mem_wr = 1'b1;
			end
			op_setp: begin
				ctrl.mem_wr = 1'b1;
				ctrl.pop    = 1'b1;
			end
			op_srf, op_out, op_isrf, op_pop: begin
				ctrl.pop = 1'b1;
			end
			op_sadd, op_smlt, op_sdiv, op_smod, op_sand, op_sland,
			op_sor, op_slor, op_sxor, op_sequ, op_sgre, op_sles,
			op_sshr, op_sshl, op_ssrs, op_ssign: begin
				ctrl.pop = 1'b1;     // Stack forms consume the top operand
			end
			op_ildi: begin
				ctrl.ldi  = 1'b1;
				ctrl.invl = 1'b1;
			end
			op_ldi: begin
				ctrl.ldi = 1'b1;
			end
			default: ;     // Everything else leaves memory and stack alone
		endcase
	end

endmodule

`default_nettype wire

//--- decode/exec_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module exec_decoder (
	input  logic                 clk,
	input  logic                 rst,
	input  decoder_pkg::opcode_t opcode,
	exec_ctrl_if.src             ctrl
);
	import decoder_pkg::*;

	alu_op_e alu_op_d;
	logic    srf_d;
	logic    invr_d;
	logic    req_in_d;
	logic    out_en_d;

	// ALU code for the instruction now on the opcode bus
	always_comb begin
		case (opcode)
			op_load, op_pld, op_setp, op_in: alu_op_d = alu_load;
			op_ildi, op_ldi, op_pop:         alu_op_d = alu_load;     // Loads through memory read data
			op_neg:                          alu_op_d = alu_neg;
			op_add, op_sadd:                 alu_op_d = alu_add;
			op_mlt, op_smlt:                 alu_op_d = alu_mul;
			op_div, op_sdiv:                 alu_op_d = alu_div;
			op_mod, op_smod:                 alu_op_d = alu_mod;
			op_and, op_sand:                 alu_op_d = alu_and;
			op_land, op_sland:               alu_op_d = alu_land;
			op_or, op_sor:                   alu_op_d = alu_or;
			op_lor, op_slor:                 alu_op_d = alu_lor;
			op_xor, op_sxor:                 alu_op_d = alu_xor;
			op_equ, op_sequ:                 alu_op_d = alu_equ;
			op_gre, op_sgre:                 alu_op_d = alu_gre;
			op_les, op_sles:                 alu_op_d = alu_les;
			op_shr, op_sshr:                 alu_op_d = alu_shr;
			op_shl, op_sshl:                 alu_op_d = alu_shl;
			op_srs, op_ssrs:                 alu_op_d = alu_srs;
			op_inv:                          alu_op_d = alu_inv;      // Unary on accumulator
			op_linv:                         alu_op_d = alu_linv;
			op_pst:                          alu_op_d = alu_pst;
			op_ssign, op_sign:               alu_op_d = alu_sign;
			op_norm:                         alu_op_d = alu_norm;
			op_abs:                          alu_op_d = alu_abs;
			default:                         alu_op_d = alu_nop;      // Branches, stores and unused codes
		endcase
	end

	assign srf_d    = (opcode == op_srf) || (opcode == op_isrf);
	assign invr_d   = (opcode == op_isrf);
	assign req_in_d = (opcode == op_in);
	assign out_en_d = (opcode == op_out);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ctrl.alu_op <= alu_nop;
			ctrl.srf    <= 1'b0;
			ctrl.invr   <= 1'b0;
			ctrl.req_in <= 1'b0;
			ctrl.out_en <= 1'b0;
		end else begin
			ctrl.alu_op <= alu_op_d;
			ctrl.srf    <= srf_d;
			ctrl.invr   <= invr_d;
			ctrl.req_in <= req_in_d;     // Selects io_in for one cycle
			ctrl.out_en <= out_en_d;
		end
	end

endmodule

`default_nettype wire

//--- common/decoder_if.sv
`timescale 1ns/1ns
`default_nettype none

// Controls from the registered path, valid one cycle after the opcode
interface exec_ctrl_if;
	import decoder_pkg::*;

	alu_op_e alu_op;
	logic    srf;
	logic    invr;     // Inverted register file set
	logic    req_in;
	logic    out_en;

	modport src (
		output alu_op,
		output srf,
		output invr,
		output req_in,
		output out_en
	);

	modport dst (
		input invr,
		input req_in
	);
endinterface

// Controls from the combinational path, valid in the opcode cycle
interface mem_ctrl_if;
	logic mem_wr;
	logic push;
	logic pop;
	logic ldi;
	logic invl;     // Inverted indirect load

	modport src (
		output mem_wr,
		output push,
		output pop,
		output ldi,
		output invl
	);

	modport dst (
		input invl
	);
endinterface

`default_nettype wire

//--- common/decoder_pkg.sv
`include "decoder_settings.svh"
`default_nettype none

package decoder_pkg;

	typedef logic [`DEC_DATA_W-1:0]      data_t;
	typedef logic [`DEC_OPCODE_W-1:0]    opcode_t;
	typedef logic [`DEC_OPERAND_W-1:0]   operand_t;
	typedef logic [`DEC_DMEM_ADDR_W-1:0] dmem_addr_t;

	// Memory form first, stack form second where both exist
	typedef enum logic [`DEC_OPCODE_W-1:0] {
		op_load = 0,
		op_pld = 1,
		op_set = 2,
		op_setp = 3,
		op_push = 4,
		op_jz = 5,
		op_jmp = 6,
		op_call = 7,
		op_return = 8,
		op_srf = 9,
		op_in = 10,
		op_out = 11,
		op_neg = 12,
		op_add = 13, op_sadd = 14,
		op_mlt = 15, op_smlt = 16,
		op_div = 17, op_sdiv = 18,
		op_mod = 19, op_smod = 20,
		op_and = 21, op_sand = 22,
		op_land = 23, op_sland = 24,
		op_or = 25, op_sor = 26,
		op_lor = 27, op_slor = 28,
		op_xor = 29, op_sxor = 30,
		op_inv = 31,
		op_linv = 32,
		op_equ = 33, op_sequ = 34,
		op_gre = 35, op_sgre = 36,
		op_les = 37, op_sles = 38,
		op_shr = 39, op_sshr = 40,
		op_shl = 41, op_sshl = 42,
		op_srs = 43, op_ssrs = 44,
		op_pst = 45,
		op_ssign = 46,
		op_norm = 47,
		op_abs = 49,
		op_ildi = 50,     // Indirect load, inverted bit order
		op_sign = 51,
		op_ldi = 52,      // Indirect load, offset in accumulator
		op_isrf = 53,
		op_pop = 64
	} opcode_e;

	typedef enum logic [`DEC_ALU_OP_W-1:0] {
		alu_nop = 0, alu_load, alu_add, alu_mul,
		alu_div, alu_mod, alu_neg, alu_norm,
		alu_abs, alu_pst, alu_sign, alu_or,
		alu_and, alu_inv, alu_xor, alu_les,
		alu_gre, alu_equ, alu_linv, alu_land,
		alu_lor, alu_shl, alu_shr, alu_srs
	} alu_op_e;

endpackage

`default_nettype wire

//--- common/decoder_settings.svh
`ifndef DECODER_SETTINGS_SVH
`define DECODER_SETTINGS_SVH

`default_nettype none

// Data path width between memory, I/O and the ALU
`define DEC_DATA_W 32

// Instruction word fields
`define DEC_OPCODE_W 7
`define DEC_OPERAND_W 9

// Data memory is addressed by the low operand bits
`define DEC_DMEM_ADDR_W 8

// Integer and logic ALU codes only
`define DEC_ALU_OP_W 5

`default_nettype wire

`endif
